//--- files.f
hdl/dma_pkg.sv
hdl/dma_mem_arbiter.sv
hdl/dma_copy_backend.sv
hdl/dma_desc_frontend.sv
hdl/dma_desc_top.sv
tests/dma_desc_assert.sv
tests/dma_desc_checker.sv
tests/tb_dma_desc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_dma_desc -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

//--- tests/tb_dma_desc.sv
// ********************
// Testbench top for the descriptor copy engine. Holds the memory
// model, posts the descriptors and prints the closing result
// ********************

`timescale 1ns/1ps
`default_nettype none

module tb_dma_desc import dma_pkg::*; ();

  localparam int unsigned DescFifoDepth = 4;
  localparam int AddrBits = 11;
  localparam int MemWords = 2 ** AddrBits;
  localparam int NumDesc  = 12;
  localparam int DescBase = 'h010;
  localparam int SrcBase  = 'h100;
  localparam int DstBase  = 'h400;
  // Test 1, test 2, test 3 (four), test 4 (DescFifoDepth+2)
  localparam int Lens [NumDesc] = '{5, 0, 3, 6, 2, 4, 40, 2, 2, 2, 2, 2};

  logic  i_idma_backend, arst_n;
  logic  desc_post, mem_req, mem_we, mem_rsp, irq, desc_drop, busy, check_end;
  addr_t desc_addr, mem_addr;
  word_t mem_wdata, mem_rdata;
  word_t mem [MemWords];
  word_t init_mem [MemWords];
  logic [31:0] lcg_state = 32'hded95a8b;
  int    chk_err;
  int    tb_err = 0;

  dma_desc_top #(.DescFifoDepth(DescFifoDepth)) UUT (
    .i_idma_backend(i_idma_backend), .arst_n_i(arst_n),
    .desc_post_i(desc_post), .desc_addr_i(desc_addr),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_rsp_i(mem_rsp), .mem_rdata_i(mem_rdata),
    .irq_o(irq), .desc_drop_o(desc_drop), .busy_o(busy)
  );

  dma_desc_checker #(.AddrBits(AddrBits)) u_checker (
    .i_idma_backend(i_idma_backend), .arst_n_i(arst_n),
    .post_i(desc_post), .post_addr_i(desc_addr), .drop_i(desc_drop), .irq_i(irq),
    .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
    .mem_wdata_i(mem_wdata), .end_i(check_end), .err_cnt_o(chk_err)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int total_words();
    int sum;
    sum = 0;
    for (int i = 0; i < NumDesc; i++) sum += Lens[i];
    return sum;
  endfunction

  task automatic fill_memory();
    int a, i, d;
    for (a = 0; a < MemWords; a++) begin
      lcg_state = lcg_next(lcg_state);
      init_mem[a] = lcg_state;
    end
    for (i = 0; i < NumDesc; i++) begin
      d = DescBase + 4 * i;
      init_mem[d + DescSrcIdx] = word_t'(SrcBase + 48 * i);
      init_mem[d + DescDstIdx] = word_t'(DstBase + 48 * i);
      init_mem[d + DescLenIdx][15:0] = len_t'(Lens[i]); // Upper half stays random
    end
    for (a = 0; a < MemWords; a++) mem[a] = init_mem[a];
  endtask

  // Back-to-back posts, entered and left 2 ns after a rising edge
  task automatic post_burst(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      desc_post = 1'b1;
      desc_addr = addr_t'(DescBase + 4 * i);
      @(posedge i_idma_backend);
      #2;
    end
    desc_post = 1'b0;
  endtask

  // Waits for n completion interrupts
  task automatic wait_done(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge i_idma_backend);
      if (irq) seen++;
    end
    repeat (3) @(posedge i_idma_backend);
    #2;
  endtask

  task automatic check_quiet(input string when);
    @(negedge i_idma_backend);
    if (busy !== 1'b0) begin
      tb_err++;
      $display("[ERROR] busy_o %s expected 0 got %h", when, busy);
    end
    if (mem_req !== 1'b0) begin
      tb_err++;
      $display("[ERROR] mem_req_o %s expected 0 got %h", when, mem_req);
    end
  endtask

  initial begin
    i_idma_backend = 1'b0;
    forever #20 i_idma_backend = ~i_idma_backend;
  end

  // One request in flight at a time, answered after 1 to 4 cycles
  initial begin : memory_model
    int    gap;
    addr_t a;
    forever begin
      @(negedge i_idma_backend);
      if (mem_req) begin
        a = mem_addr;
        if (mem_we) mem[a[AddrBits-1:0]] = mem_wdata;
        lcg_state = lcg_next(lcg_state);
        gap = 1 + int'(lcg_state[29:28]);
        repeat (gap) @(posedge i_idma_backend);
        #2;
        mem_rsp   = 1'b1;
        mem_rdata = mem[a[AddrBits-1:0]];
        @(posedge i_idma_backend);
        #2;
        mem_rsp   = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (total_words() * 12 + 200) @(posedge i_idma_backend);
    $display("Watchdog expired, the engine did not drain in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin : stimulus
    arst_n    = 1'b0;
    desc_post = 1'b0;
    desc_addr = '0;
    mem_rsp   = 1'b0;
    mem_rdata = '0;
    check_end = 1'b0;
    fill_memory();
    repeat (3) @(posedge i_idma_backend);
    #2 arst_n = 1'b1;
    check_quiet("after reset");
    @(posedge i_idma_backend);
    #2;
    post_burst(0, 1);                  // Five words
    wait_done(1);
    post_burst(1, 1);                  // Zero length
    wait_done(1);
    post_burst(2, 4);
    wait_done(4);
    post_burst(6, DescFifoDepth + 2);  // Long first copy, queue overflows
    wait_done(DescFifoDepth + 1);      // Last post finds the queue full
    check_quiet("after drain");
    check_end = 1'b1;
    repeat (2) @(posedge i_idma_backend);
    $display("Errors: checker %0d, testbench %0d", chk_err, tb_err);
    if (chk_err + tb_err == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_dma_desc

`default_nettype wire

//--- tests/dma_desc_checker.sv
// ********************
// Watches the DUT, compares every memory write with the reference
// copy order and runs the closing checks when end_i rises
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_desc_checker import dma_pkg::*; #(
  parameter int AddrBits = 11
) (
  input  wire logic  i_idma_backend,
  input  wire logic  arst_n_i,
  input  wire logic  post_i,
  input  wire addr_t post_addr_i,
  input  wire logic  drop_i,
  input  wire logic  irq_i,
  input  wire logic  mem_req_i,
  input  wire logic  mem_we_i,
  input  wire addr_t mem_addr_i,
  input  wire word_t mem_wdata_i,
  input  wire logic  end_i,
  output int         err_cnt_o
);

  addr_t       descs [$];  // Accepted posts in order
  word_t       img [2 ** AddrBits];
  logic [63:0] exp_wr;
  int          errs = 0;
  int          n_wr = 0;
  int          n_irq = 0;
  int          n_drop = 0;
  logic        ended = 1'b0;

  assign err_cnt_o = errs;

  function automatic word_t init_word(input addr_t a);
    return tb_dma_desc.init_mem[a[AddrBits-1:0]];
  endfunction

  function automatic int desc_len(input addr_t d);
    return int'(len_t'(init_word(d + DescLenIdx)));
  endfunction

  // Expected {address, data} of the k-th memory write of the run
  function automatic logic [63:0] ref_write(input int k);
    int    rem;
    addr_t src, dst;
    rem = k;
    foreach (descs[i]) begin
      src = init_word(descs[i] + DescSrcIdx);
      dst = init_word(descs[i] + DescDstIdx);
      if (rem < desc_len(descs[i])) return {dst + addr_t'(rem), init_word(src + addr_t'(rem))};
      rem -= desc_len(descs[i]);
    end
    return '1;
  endfunction

  task automatic final_checks();
    int a, k, total;
    total = 0;
    foreach (descs[i]) total += desc_len(descs[i]);
    if (n_wr != total) begin
      errs++;
      $display("Saw %0d memory writes but expected %0d", n_wr, total);
    end
    if (n_irq != descs.size()) begin
      errs++;
      $display("Saw %0d interrupts but %0d descriptors were accepted", n_irq, descs.size());
    end
    if (n_drop == 0) begin
      errs++;
      $display("No post was dropped although the queue overflowed");
    end
    for (a = 0; a < 2 ** AddrBits; a++) img[a] = tb_dma_desc.init_mem[a];
    for (k = 0; k < total; k++) begin
      exp_wr = ref_write(k);
      img[exp_wr[32 +: AddrBits]] = exp_wr[31:0];
    end
    for (a = 0; a < 2 ** AddrBits; a++) begin
      if (img[a] !== tb_dma_desc.mem[a]) begin
        errs++;
        $display("[ERROR] mem[%h] expected %h got %h", a, img[a], tb_dma_desc.mem[a]);
      end
    end
  endtask

  always @(negedge i_idma_backend) begin
    if (arst_n_i) begin
      if (drop_i) begin   // Belongs to the post of the previous cycle
        void'(descs.pop_back());
        n_drop++;
      end
      if (post_i) descs.push_back(post_addr_i);
      if (irq_i) n_irq++;
      if (mem_req_i && mem_we_i) begin
        exp_wr = ref_write(n_wr);
        if (mem_addr_i !== exp_wr[63:32]) begin
          errs++;
          $display("[ERROR] mem_addr_o expected %h got %h", exp_wr[63:32], mem_addr_i);
        end
        if (mem_wdata_i !== exp_wr[31:0]) begin
          errs++;
          $display("[ERROR] mem_wdata_o expected %h got %h", exp_wr[31:0], mem_wdata_i);
        end
        n_wr++;
      end
      if (end_i && !ended) begin
        ended = 1'b1;
        final_checks();
      end
    end
  end

endmodule : dma_desc_checker

`default_nettype wire

//--- tests/dma_desc_assert.sv
// ********************
// Memory port and interrupt protocol assertions, bound to the top
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_desc_assert (
  input wire logic i_idma_backend,
  input wire logic arst_n_i,
  input wire logic mem_req_o,
  input wire logic mem_rsp_i,
  input wire logic irq_o
);

  logic pending_q;  // Request issued, response not yet seen

  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else if (mem_req_o) begin
      pending_q <= 1'b1;
    end else if (mem_rsp_i) begin
      pending_q <= 1'b0;
    end
  end

  a_single_outstanding: assert property (@(posedge i_idma_backend) disable iff (!arst_n_i)
    mem_req_o |-> !pending_q) else $error("Memory request while another is outstanding");

  a_irq_one_cycle: assert property (@(posedge i_idma_backend) disable iff (!arst_n_i)
    irq_o |=> !irq_o) else $error("Interrupt held longer than one cycle");

  a_quiet_in_reset: assert property (@(posedge i_idma_backend)
    !arst_n_i |-> !mem_req_o) else $error("Memory request during reset");

endmodule : dma_desc_assert

bind dma_desc_top dma_desc_assert u_assert (
  .i_idma_backend(i_idma_backend),
  .arst_n_i(arst_n_i),
  .mem_req_o(mem_req_o),
  .mem_rsp_i(mem_rsp_i),
  .irq_o(irq_o)
);

`default_nettype wire

//--- hdl/dma_desc_top.sv
// ********************
// Top level of the descriptor copy engine. Frontend and backend
// share the single memory port through the arbiter
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_desc_top import dma_pkg::*; #(
  parameter int unsigned DescFifoDepth = 4
) (
  input  wire logic  i_idma_backend,
  input  wire logic  arst_n_i,
  input  wire logic  desc_post_i,
  input  wire addr_t desc_addr_i,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  input  wire logic  mem_rsp_i,
  input  wire word_t mem_rdata_i,
  output logic       irq_o,
  output logic       desc_drop_o,
  output logic       busy_o
);

  logic  fe_req, fe_rsp;
  addr_t fe_addr;
  logic  be_req, be_we, be_rsp;
  addr_t be_addr;
  word_t be_wdata;
  word_t rsp_data;

  logic  desc_start, desc_done;
  addr_t desc_src, desc_dst;
  len_t  desc_len;

  dma_desc_frontend #(
    .DescFifoDepth ( DescFifoDepth )
  ) u_frontend (
    .i_idma_backend ( i_idma_backend ),
    .arst_n_i       ( arst_n_i       ),
    .desc_post_i    ( desc_post_i    ),
    .desc_addr_i    ( desc_addr_i    ),
    .mem_rsp_i      ( fe_rsp         ),
    .rsp_data_i     ( rsp_data       ),
    .desc_done_i    ( desc_done      ),
    .mem_req_o      ( fe_req         ),
    .mem_addr_o     ( fe_addr        ),
    .desc_start_o   ( desc_start     ),
    .desc_src_o     ( desc_src       ),
    .desc_dst_o     ( desc_dst       ),
    .desc_len_o     ( desc_len       ),
    .irq_o          ( irq_o          ),
    .desc_drop_o    ( desc_drop_o    ),
    .busy_o         ( busy_o         )
  );

  dma_copy_backend u_backend (
    .i_idma_backend ( i_idma_backend ),
    .arst_n_i       ( arst_n_i       ),
    .desc_start_i   ( desc_start     ),
    .desc_src_i     ( desc_src       ),
    .desc_dst_i     ( desc_dst       ),
    .desc_len_i     ( desc_len       ),
    .mem_rsp_i      ( be_rsp         ),
    .rsp_data_i     ( rsp_data       ),
    .mem_req_o      ( be_req         ),
    .mem_we_o       ( be_we          ),
    .mem_addr_o     ( be_addr        ),
    .mem_wdata_o    ( be_wdata       ),
    .desc_done_o    ( desc_done      )
  );

  dma_mem_arbiter u_arbiter (
    .i_idma_backend ( i_idma_backend ),
    .arst_n_i       ( arst_n_i       ),
    .fe_req_i       ( fe_req         ),
    .fe_addr_i      ( fe_addr        ),
    .be_req_i       ( be_req         ),
    .be_we_i        ( be_we          ),
    .be_addr_i      ( be_addr        ),
    .be_wdata_i     ( be_wdata       ),
    .mem_rsp_i      ( mem_rsp_i      ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .fe_rsp_o       ( fe_rsp         ),
    .be_rsp_o       ( be_rsp         ),
    .rsp_data_o     ( rsp_data       ),
    .mem_req_o      ( mem_req_o      ),
    .mem_we_o       ( mem_we_o       ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    )
  );

endmodule : dma_desc_top

`default_nettype wire

//--- hdl/dma_desc_frontend.sv
// ********************
// Descriptor frontend. Queues posted descriptor addresses, fetches
// each descriptor and hands it to the copy backend, raises irq_o
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_desc_frontend import dma_pkg::*; #(
  parameter int unsigned DescFifoDepth = 4
) (
  input  wire logic  i_idma_backend,
  input  wire logic  arst_n_i,
  input  wire logic  desc_post_i,
  input  wire addr_t desc_addr_i,
  input  wire logic  mem_rsp_i,
  input  wire word_t rsp_data_i,
  input  wire logic  desc_done_i,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  output logic       desc_start_o,
  output addr_t      desc_src_o,
  output addr_t      desc_dst_o,
  output len_t       desc_len_o,
  output logic       irq_o,
  output logic       desc_drop_o,
  output logic       busy_o
);

  localparam int unsigned PtrW = (DescFifoDepth > 1) ? $clog2(DescFifoDepth) : 1;
  localparam int unsigned CntW = $clog2(DescFifoDepth + 1);
  localparam int unsigned IdxW = $clog2(DescWords);

  addr_t           fifo_q [DescFifoDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            fifo_full, fifo_empty;
  logic            push, pop;

  fe_state_t       state_q;
  logic [IdxW-1:0] idx_q;
  addr_t           base_q;
  logic            be_busy_q;

  assign fifo_full  = (cnt_q == CntW'(DescFifoDepth));
  assign fifo_empty = (cnt_q == '0);
  assign push       = desc_post_i && !fifo_full;
  assign pop        = (state_q == FE_IDLE) && !fifo_empty;

  always_ff @(posedge i_idma_backend) begin
    if (push) fifo_q[wr_ptr_q] <= desc_addr_i;
  end

  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PtrW'(DescFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PtrW'(DescFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  // Fetch FSM, one word request outstanding at a time
  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FE_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        FE_IDLE: if (pop) begin
          idx_q   <= '0;
          state_q <= FE_FETCH;
        end
        FE_FETCH: state_q <= FE_WAIT_RSP;
        FE_WAIT_RSP: if (mem_rsp_i) begin
          if (idx_q == IdxW'(DescWords - 1)) begin
            state_q <= FE_HANDOFF;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= FE_FETCH;
          end
        end
        FE_HANDOFF: if (!be_busy_q) state_q <= FE_IDLE;
        default: state_q <= FE_IDLE;
      endcase
    end
  end

  // Holding registers for the descriptor being fetched
  always_ff @(posedge i_idma_backend) begin
    if (pop) base_q <= fifo_q[rd_ptr_q];
    if (state_q == FE_WAIT_RSP && mem_rsp_i) begin
      if (idx_q == IdxW'(DescSrcIdx)) desc_src_o <= rsp_data_i;
      if (idx_q == IdxW'(DescDstIdx)) desc_dst_o <= rsp_data_i;
      if (idx_q == IdxW'(DescLenIdx)) desc_len_o <= rsp_data_i[$bits(len_t)-1:0];
    end
  end

  assign mem_req_o    = (state_q == FE_FETCH);
  assign mem_addr_o   = base_q + addr_t'(idx_q);
  assign desc_start_o = (state_q == FE_HANDOFF) && !be_busy_q;

  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      be_busy_q   <= 1'b0;
      irq_o       <= 1'b0;
      desc_drop_o <= 1'b0;
    end else begin
      if (desc_start_o)     be_busy_q <= 1'b1;
      else if (desc_done_i) be_busy_q <= 1'b0;
      irq_o       <= desc_done_i;
      desc_drop_o <= desc_post_i && fifo_full; // Post lost, queue full
    end
  end

  assign busy_o = !fifo_empty || (state_q != FE_IDLE) || be_busy_q;

endmodule : dma_desc_frontend

`default_nettype wire

//--- hdl/dma_copy_backend.sv
// ********************
// Copy backend. Moves one descriptor word by word, a read of the
// source followed by a write to the destination for each word
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_copy_backend import dma_pkg::*; (
  input  wire logic  i_idma_backend,
  input  wire logic  arst_n_i,
  input  wire logic  desc_start_i,
  input  wire addr_t desc_src_i,
  input  wire addr_t desc_dst_i,
  input  wire len_t  desc_len_i,
  input  wire logic  mem_rsp_i,
  input  wire word_t rsp_data_i,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o,
  output logic       desc_done_o
);

  be_state_t state_q;
  addr_t     src_q, dst_q;
  len_t      len_q;
  len_t      cnt_q;   // Index of the word in flight
  word_t     data_q;
  logic      last_word;

  assign last_word = (cnt_q == len_q - 1'b1);

  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= BE_IDLE;
      cnt_q       <= '0;
      desc_done_o <= 1'b0;
    end else begin
      desc_done_o <= 1'b0;
      case (state_q)
        BE_IDLE: if (desc_start_i) begin
          cnt_q <= '0;
          if (desc_len_i == '0) desc_done_o <= 1'b1; // Nothing to move
          else                  state_q     <= BE_READ;
        end
        BE_READ:      state_q <= BE_WAIT_READ;
        BE_WAIT_READ: if (mem_rsp_i) state_q <= BE_WRITE;
        BE_WRITE:     state_q <= BE_WAIT_WRITE;
        BE_WAIT_WRITE: if (mem_rsp_i) begin
          if (last_word) begin
            desc_done_o <= 1'b1;
            state_q     <= BE_IDLE;
          end else begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= BE_READ;
          end
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

  // Descriptor fields and the word in transit
  always_ff @(posedge i_idma_backend) begin
    if (state_q == BE_IDLE && desc_start_i) begin
      src_q <= desc_src_i;
      dst_q <= desc_dst_i;
      len_q <= desc_len_i;
    end
    if (state_q == BE_WAIT_READ && mem_rsp_i) data_q <= rsp_data_i;
  end

  assign mem_req_o   = (state_q == BE_READ) || (state_q == BE_WRITE);
  assign mem_we_o    = (state_q == BE_WRITE);
  assign mem_addr_o  = (mem_we_o ? dst_q : src_q) + addr_t'(cnt_q);
  assign mem_wdata_o = data_q;

endmodule : dma_copy_backend

`default_nettype wire

//--- hdl/dma_mem_arbiter.sv
// ********************
// Two-client memory arbiter. Holds one pending request per client,
// keeps one request in flight and steers the response to its owner
// ********************

`timescale 1ns/1ps
`default_nettype none

module dma_mem_arbiter import dma_pkg::*; (
  input  wire logic  i_idma_backend,
  input  wire logic  arst_n_i,
  input  wire logic  fe_req_i,
  input  wire addr_t fe_addr_i,
  input  wire logic  be_req_i,
  input  wire logic  be_we_i,
  input  wire addr_t be_addr_i,
  input  wire word_t be_wdata_i,
  input  wire logic  mem_rsp_i,
  input  wire word_t mem_rdata_i,
  output logic       fe_rsp_o,
  output logic       be_rsp_o,
  output word_t      rsp_data_o,
  output logic       mem_req_o,
  output logic       mem_we_o,
  output addr_t      mem_addr_o,
  output word_t      mem_wdata_o
);

  logic  fe_pend_q, be_pend_q;
  addr_t fe_addr_q, be_addr_q;
  logic  be_we_q;
  word_t be_wdata_q;
  logic  out_q;       // Request in flight on the memory port
  logic  owner_q;     // 1 when the backend owns it
  logic  last_be_q;   // Backend was granted last
  logic  grant_fe, grant_be;

  // Round robin when both are waiting
  assign grant_fe = !out_q && fe_pend_q && (!be_pend_q || last_be_q);
  assign grant_be = !out_q && be_pend_q && (!fe_pend_q || !last_be_q);

  always_ff @(posedge i_idma_backend) begin
    if (fe_req_i) fe_addr_q <= fe_addr_i;
    if (be_req_i) begin
      be_we_q    <= be_we_i;
      be_addr_q  <= be_addr_i;
      be_wdata_q <= be_wdata_i;
    end
  end

  always_ff @(posedge i_idma_backend or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fe_pend_q <= 1'b0;
      be_pend_q <= 1'b0;
      out_q     <= 1'b0;
      owner_q   <= 1'b0;
      last_be_q <= 1'b0;
    end else begin
      if (fe_req_i)      fe_pend_q <= 1'b1;
      else if (grant_fe) fe_pend_q <= 1'b0;
      if (be_req_i)      be_pend_q <= 1'b1;
      else if (grant_be) be_pend_q <= 1'b0;

      if (grant_fe || grant_be) begin
        out_q     <= 1'b1;
        owner_q   <= grant_be;
        last_be_q <= grant_be;
      end else if (mem_rsp_i) begin
        out_q <= 1'b0;
      end
    end
  end

  assign mem_req_o   = grant_fe || grant_be;
  assign mem_we_o    = grant_be && be_we_q;
  assign mem_addr_o  = grant_be ? be_addr_q : fe_addr_q;
  assign mem_wdata_o = be_wdata_q;

  assign fe_rsp_o   = mem_rsp_i && out_q && !owner_q;
  assign be_rsp_o   = mem_rsp_i && out_q && owner_q;
  assign rsp_data_o = mem_rdata_i;

endmodule : dma_mem_arbiter

`default_nettype wire

//--- hdl/dma_pkg.sv
// ********************
// Shared widths, descriptor layout and FSM state encodings
// for the descriptor copy engine. Imported by every RTL module.
// ********************

`default_nettype none

package dma_pkg;

  // Word-addressed memory
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Copy length in words, low half of descriptor word 2
  typedef logic [15:0] len_t;

  // Descriptor layout in memory
  localparam int unsigned DescWords  = 3;
  localparam int unsigned DescSrcIdx = 0;
  localparam int unsigned DescDstIdx = 1;
  localparam int unsigned DescLenIdx = 2;

  typedef enum logic [1:0] {
    FE_IDLE,
    FE_FETCH,    // Request strobe for one descriptor word
    FE_WAIT_RSP,
    FE_HANDOFF   // Descriptor complete, waiting for an idle backend
  } fe_state_t;

  typedef enum logic [2:0] {
    BE_IDLE,
    BE_READ,
    BE_WAIT_READ,
    BE_WRITE,
    BE_WAIT_WRITE
  } be_state_t;

endpackage : dma_pkg

`default_nettype wire
